//--- list.f
hw/ctrlPkg.sv
hw/decodeIf.sv
hw/instrDecoder.sv
hw/ctrlSequencer.sv
hw/ctrlOutputs.sv
hw/multicycleCtrl.sv
tests/multicycleCtrl_asserts.sv
tests/multicycleCtrlTb.sv

//--- Bender.yml
package:
  name: multicycle_ctrl

sources:
  - hw/ctrlPkg.sv
  - hw/decodeIf.sv
  - hw/instrDecoder.sv
  - hw/ctrlSequencer.sv
  - hw/ctrlOutputs.sv
  - hw/multicycleCtrl.sv
  - target: test
    files:
      - tests/multicycleCtrl_asserts.sv
      - tests/multicycleCtrlTb.sv

//--- tests/multicycleCtrlTb.sv
module multicycleCtrlTb;
    timeunit 1ns;
    timeprecision 1ps;
    import ctrlPkg::*;

    logic       clk;
    logic       arstN;
    logic       instrValid;
    logic       instrReady;
    logic [5:0] op;
    logic [5:0] funct;
    logic       pcWrite;
    logic       pcWriteCond;
    logic       irWrite;
    logic       regWrite;
    logic       memRead;
    logic       memWrite;
    logic       illegalInstr;
    pcSrcT      pcSrc;
    regDstT     regDst;
    memToRegT   memToReg;
    aluSrcAT    aluSrcA;
    aluSrcBT    aluSrcB;
    aluOpT      aluOp;

    integer     seed;
    logic [5:0] opTab[$];
    logic [5:0] functTab[$];

    bind multicycleCtrl multicycleCtrl_asserts asserts_i (.*);

    multicycleCtrl dut_i (.*);

    always #50 clk = ~clk;

    always @(negedge clk)
    begin
        if (dut_i.asserts_i.failCount != 0)
        begin
            $display("Test failed");
            $fatal(1, "assertion failure seen");
        end
    end

    task automatic addCode(input logic [5:0] o, input logic [5:0] f);
        opTab.push_back(o);
        functTab.push_back(f);
    endtask

    task automatic buildTable();
        logic [5:0] rFns [16];
        logic [5:0] iOps [19];
        rFns = '{fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor,
                 fnSll, fnSllv, fnSrl, fnSrlv, fnJr, fnJalr, 6'h2a, 6'h0c};  // Last two illegal
        iOps = '{opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui,
                 opLw, opSw, opBeq, opBne, opBgtz, opBlez, opJ, opJal,
                 6'h01, 6'h20, 6'h3f};                                      // Illegal tail
        foreach (rFns[i])
            addCode(opRtype, rFns[i]);
        foreach (iOps[i])
            addCode(iOps[i], 6'h00);
    endtask

    task automatic waitReady();
        int n;
        n = 0;
        @(negedge clk);
        while (!instrReady)
        begin
            if (n == 10)
            begin
                $display("Timeout: instrReady stayed low for 10 cycles");
                $display("Test failed");
                $fatal(1, "handshake timeout");
            end
            else
            begin
                @(negedge clk);
                n++;
            end
        end
    endtask

    task automatic sendOne();
        int         r;
        int         idx;
        logic [5:0] f;
        r = $random(seed);
        if (r[1:0] != 2'd0)
        begin
            instrValid <= 1'b0;
            waitReady();
            repeat (r[1:0]) @(posedge clk);   // Withhold valid in stFetch
        end
        r = $random(seed);
        idx = (r & 32'h7fff_ffff) % opTab.size();
        f = functTab[idx];
        if (opTab[idx] != opRtype)
        begin
            r = $random(seed);
            f = r[5:0];                   // Don't-care field
        end
        instrValid <= 1'b1;
        op         <= opTab[idx];
        funct      <= f;
        waitReady();
        @(posedge clk);                   // Accept edge
    endtask

    initial
    begin
        clk        = 1'b0;
        arstN      = 1'b0;
        instrValid = 1'b0;
        op         = '0;
        funct      = '0;
        seed       = 32'h8e4c_1af2;
        buildTable();
        repeat (3) @(posedge clk);
        arstN <= 1'b1;
        for (int i = 0; i < 400; i++)
        begin
            sendOne();
        end
        instrValid <= 1'b0;
        waitReady();
        repeat (2) @(posedge clk);
        if (dut_i.asserts_i.failCount == 0)
        begin
            $display("Test passed");
            $finish;
        end
        else
        begin
            $display("Test failed");
            $fatal(1, "assertion failures at end of run");
        end
    end

endmodule

//--- tests/multicycleCtrl_asserts.sv
module multicycleCtrl_asserts (
    input logic               clk,
    input logic               arstN,
    input logic               instrValid,
    input logic               instrReady,
    input logic [5:0]         op,
    input logic [5:0]         funct,
    input ctrlPkg::ctrlStateT state,
    input logic               pcWrite,
    input logic               pcWriteCond,
    input logic               irWrite,
    input logic               regWrite,
    input logic               memRead,
    input logic               memWrite,
    input logic               illegalInstr,
    input ctrlPkg::pcSrcT     pcSrc,
    input ctrlPkg::regDstT    regDst,
    input ctrlPkg::memToRegT  memToReg,
    input ctrlPkg::aluSrcAT   aluSrcA,
    input ctrlPkg::aluSrcBT   aluSrcB,
    input ctrlPkg::aluOpT     aluOp
);
    timeunit 1ns;
    timeprecision 1ps;
    import ctrlPkg::*;

    int         failCount = 0;
    logic       accept;
    logic       inFlight;
    logic [3:0] cnt;              // Cycles since accept
    logic [5:0] opQ;
    logic [5:0] functQ;
    instrClassT classQ;
    aluOpT      expOp;
    aluSrcBT    expSrcB;
    logic       expShamt;
    logic       expLink;
    logic       expJumpReg;
    logic [6:0] writeEns;
    int         expRet;

    function automatic instrClassT classify(input logic [5:0] o, input logic [5:0] f);
        instrClassT c;
        case (o)
            opRtype:
            begin
                case (f)
                    fnAdd, fnAddu, fnSub, fnSubu, fnAnd, fnOr, fnXor, fnNor,
                    fnSll, fnSllv, fnSrl, fnSrlv: c = clsAlu;
                    fnJr, fnJalr:                 c = clsJump;
                    default:                      c = clsIllegal;
                endcase
            end
            opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori, opLui: c = clsAlu;
            opLw:                          c = clsLoad;
            opSw:                          c = clsStore;
            opBeq, opBne, opBlez, opBgtz:  c = clsBranch;
            opJ, opJal:                    c = clsJump;
            default:                       c = clsIllegal;
        endcase
        return c;
    endfunction

    function automatic aluOpT opFor(input logic [5:0] o, input logic [5:0] f);
        aluOpT a;
        a = aluAdd;
        case (o)
            opRtype:
            begin
                case (f)
                    fnSub, fnSubu: a = aluSub;
                    fnAnd:         a = aluAnd;
                    fnOr:          a = aluOr;
                    fnXor:         a = aluXor;
                    fnNor:         a = aluNor;
                    fnSll, fnSllv: a = aluSll;
                    fnSrl, fnSrlv: a = aluSrl;
                    default:       a = aluAdd;
                endcase
            end
            opSlti:  a = aluSlt;
            opSltiu: a = aluSltu;
            opAndi:  a = aluAnd;
            opOri:   a = aluOr;
            opXori:  a = aluXor;
            opLui:   a = aluLui;
            opBeq:   a = aluSub;
            opBne:   a = aluBne;
            opBgtz:  a = aluBgtz;
            opBlez:  a = aluBlez;
            default: a = aluAdd;
        endcase
        return a;
    endfunction

    assign accept     = instrValid && instrReady;
    assign writeEns   = {pcWrite, irWrite, pcWriteCond, regWrite,
                         memRead, memWrite, illegalInstr};
    assign expOp      = opFor(opQ, functQ);
    assign expSrcB    = (classQ == clsAlu && opQ == opRtype) ? srcBRegB : srcBImm;
    assign expShamt   = (opQ == opRtype) && (functQ == fnSll || functQ == fnSrl);
    assign expLink    = (opQ == opJal) || (opQ == opRtype && functQ == fnJalr);
    assign expJumpReg = (opQ == opRtype);
    always_comb
    begin
        case (classQ)
            clsAlu:    expRet = 4;
            clsLoad:   expRet = 5;
            clsStore:  expRet = 4;
            clsBranch: expRet = 3;
            clsJump:   expRet = 3;
            default:   expRet = 2;
        endcase
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            inFlight <= 1'b0;
            cnt      <= '0;
            opQ      <= '0;
            functQ   <= '0;
            classQ   <= clsIllegal;
        end
        else if (accept)
        begin
            inFlight <= 1'b1;
            cnt      <= 4'd1;
            opQ      <= op;
            functQ   <= funct;
            classQ   <= classify(op, funct);
        end
        else if (instrReady)
        begin
            inFlight <= 1'b0;
        end
        else if (cnt != 4'hf)
        begin
            cnt <= cnt + 4'd1;
        end
    end

    task automatic reportFail(input string msg);
        failCount++;
        $error("%s", msg);
    endtask

    aNoWrite: assert property (@(posedge clk) disable iff (!arstN)
        state == stFetch && !instrValid |-> writeEns == '0)
        else reportFail($sformatf("CHECK FAILED at %0t: write enables expected %b got %b",
            $time, 7'b0, $sampled(writeEns)));

    aHold: assert property (@(posedge clk) disable iff (!arstN)
        state == stFetch && !instrValid |=> state == stFetch)
        else reportFail($sformatf("CHECK FAILED at %0t: state expected %0d got %0d",
            $time, stFetch, $sampled(state)));

    aFetch: assert property (@(posedge clk) disable iff (!arstN)
        accept |-> pcWrite && irWrite && aluSrcB == srcBFour)
        else reportFail($sformatf(
            "CHECK FAILED at %0t: pcWrite/irWrite/aluSrcB expected 1/1/%0d got %b/%b/%0d",
            $time, srcBFour, $sampled(pcWrite), $sampled(irWrite), $sampled(aluSrcB)));

    aAluOp: assert property (@(posedge clk) disable iff (!arstN)
        inFlight && cnt == 2 && classQ == clsAlu |-> aluOp == expOp)
        else reportFail($sformatf("CHECK FAILED at %0t: aluOp expected %0d got %0d",
            $time, $sampled(expOp), $sampled(aluOp)));

    aShamt: assert property (@(posedge clk) disable iff (!arstN)
        inFlight && cnt == 2 && classQ == clsAlu |-> (aluSrcA == srcAShamt) == expShamt)
        else reportFail($sformatf("CHECK FAILED at %0t: aluSrcA is shamt expected %b got %b",
            $time, $sampled(expShamt), $sampled(aluSrcA) == srcAShamt));

    aSrcB: assert property (@(posedge clk) disable iff (!arstN)
        inFlight && cnt == 2 && classQ inside {clsAlu, clsLoad, clsStore} |->
        aluSrcB == expSrcB)
        else reportFail($sformatf("CHECK FAILED at %0t: aluSrcB expected %0d got %0d",
            $time, $sampled(expSrcB), $sampled(aluSrcB)));

    aAluWb: assert property (@(posedge clk) disable iff (!arstN)
        inFlight && cnt == 3 && classQ == clsAlu |->
        regWrite && memToReg == wbAlu && regDst == (expJumpReg ? dstRd : dstRt))
        else reportFail($sformatf(
            "CHECK FAILED at %0t: regWrite/memToReg/regDst expected 1/%0d/%0d got %b/%0d/%0d",
            $time, wbAlu, $sampled(expJumpReg) ? dstRd : dstRt,
            $sampled(regWrite), $sampled(memToReg), $sampled(regDst)));

    aLoadRead: assert property (@(posedge clk) disable iff (!arstN)
        inFlight && cnt == 3 && classQ == clsLoad |-> memRead)
        else reportFail($sformatf("CHECK FAILED at %0t: memRead expected 1 got %b",
            $time, $sampled(memRead)));

    aLoadWb: assert property (@(posedge clk) disable iff (!arstN)
        inFlight && cnt == 4 && classQ == clsLoad |->
        regWrite && memToReg == wbMem && regDst == dstRt)
        else reportFail($sformatf(
            "CHECK FAILED at %0t: regWrite/memToReg/regDst expected 1/%0d/%0d got %b/%0d/%0d",
            $time, wbMem, dstRt, $sampled(regWrite), $sampled(memToReg), $sampled(regDst)));

    aStoreWrite: assert property (@(posedge clk) disable iff (!arstN)
        inFlight && cnt == 3 && classQ == clsStore |-> memWrite)
        else reportFail($sformatf("CHECK FAILED at %0t: memWrite expected 1 got %b",
            $time, $sampled(memWrite)));

    aStoreNoWb: assert property (@(posedge clk) disable iff (!arstN)
        inFlight && classQ == clsStore |-> !regWrite)
        else reportFail($sformatf("CHECK FAILED at %0t: regWrite expected 0 got %b",
            $time, $sampled(regWrite)));

    aBranch: assert property (@(posedge clk) disable iff (!arstN)
        inFlight && cnt == 2 && classQ == clsBranch |->
        pcWriteCond && pcSrc == pcBranch && aluOp == expOp)
        else reportFail($sformatf(
            "CHECK FAILED at %0t: pcWriteCond/pcSrc/aluOp expected 1/%0d/%0d got %b/%0d/%0d",
            $time, pcBranch, $sampled(expOp),
            $sampled(pcWriteCond), $sampled(pcSrc), $sampled(aluOp)));

    aJump: assert property (@(posedge clk) disable iff (!arstN)
        inFlight && cnt == 2 && classQ == clsJump |->
        pcWrite && pcSrc == (expJumpReg ? pcReg : pcJump) && regWrite == expLink)
        else reportFail($sformatf(
            "CHECK FAILED at %0t: pcWrite/pcSrc/regWrite expected 1/%0d/%b got %b/%0d/%b",
            $time, $sampled(expJumpReg) ? pcReg : pcJump, $sampled(expLink),
            $sampled(pcWrite), $sampled(pcSrc), $sampled(regWrite)));

    aLinkDst: assert property (@(posedge clk) disable iff (!arstN)
        inFlight && classQ == clsJump && regWrite |->
        regDst == dstRa && memToReg == wbPcPlus4)
        else reportFail($sformatf(
            "CHECK FAILED at %0t: regDst/memToReg expected %0d/%0d got %0d/%0d",
            $time, dstRa, wbPcPlus4, $sampled(regDst), $sampled(memToReg)));

    aIllegal: assert property (@(posedge clk) disable iff (!arstN)
        inFlight && cnt == 1 |-> illegalInstr == (classQ == clsIllegal))
        else reportFail($sformatf("CHECK FAILED at %0t: illegalInstr expected %b got %b",
            $time, $sampled(classQ) == clsIllegal, $sampled(illegalInstr)));

    aReturn: assert property (@(posedge clk) disable iff (!arstN)
        inFlight && instrReady |-> cnt == expRet)
        else reportFail($sformatf("CHECK FAILED at %0t: instrReady cycle expected %0d got %0d",
            $time, $sampled(expRet), $sampled(cnt)));

endmodule

//--- hw/multicycleCtrl.sv
module multicycleCtrl (
    input  logic              clk,
    input  logic              arstN,
    input  logic              instrValid,
    output logic              instrReady,
    input  logic [5:0]        op,
    input  logic [5:0]        funct,
    output logic              pcWrite,
    output logic              pcWriteCond,
    output logic              irWrite,
    output logic              regWrite,
    output logic              memRead,
    output logic              memWrite,
    output logic              illegalInstr,
    output ctrlPkg::pcSrcT    pcSrc,
    output ctrlPkg::regDstT   regDst,
    output ctrlPkg::memToRegT memToReg,
    output ctrlPkg::aluSrcAT  aluSrcA,
    output ctrlPkg::aluSrcBT  aluSrcB,
    output ctrlPkg::aluOpT    aluOp
);
    import ctrlPkg::*;

    ctrlStateT state;

    decodeIf decBus ();

    instrDecoder decoder_i (
        .clk   (clk),
        .arstN (arstN),
        .op    (op),
        .funct (funct),
        .dec   (decBus.decoder)
    );

    ctrlSequencer sequencer_i (
        .clk        (clk),
        .arstN      (arstN),
        .instrValid (instrValid),
        .instrReady (instrReady),
        .state      (state),
        .dec        (decBus.sequencer)
    );

    ctrlOutputs outputs_i (
        .state        (state),
        .instrValid   (instrValid),
        .dec          (decBus.outputs),
        .pcWrite      (pcWrite),
        .pcWriteCond  (pcWriteCond),
        .irWrite      (irWrite),
        .regWrite     (regWrite),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .illegalInstr (illegalInstr),
        .pcSrc        (pcSrc),
        .regDst       (regDst),
        .memToReg     (memToReg),
        .aluSrcA      (aluSrcA),
        .aluSrcB      (aluSrcB),
        .aluOp        (aluOp)
    );

endmodule

//--- hw/ctrlOutputs.sv
module ctrlOutputs (
    input  ctrlPkg::ctrlStateT state,
    input  logic               instrValid,
    decodeIf.outputs           dec,
    output logic               pcWrite,
    output logic               pcWriteCond,
    output logic               irWrite,
    output logic               regWrite,
    output logic               memRead,
    output logic               memWrite,
    output logic               illegalInstr,
    output ctrlPkg::pcSrcT     pcSrc,
    output ctrlPkg::regDstT    regDst,
    output ctrlPkg::memToRegT  memToReg,
    output ctrlPkg::aluSrcAT   aluSrcA,
    output ctrlPkg::aluSrcBT   aluSrcB,
    output ctrlPkg::aluOpT     aluOp
);
    import ctrlPkg::*;

    always_comb
    begin
        pcWrite      = 1'b0;
        pcWriteCond  = 1'b0;
        irWrite      = 1'b0;
        regWrite     = 1'b0;
        memRead      = 1'b0;
        memWrite     = 1'b0;
        illegalInstr = 1'b0;
        pcSrc        = pcPlus4;
        regDst       = dstRt;
        memToReg     = wbAlu;
        aluSrcA      = srcARegA;
        aluSrcB      = srcBRegB;
        aluOp        = aluAdd;
        case (state)
            stFetch:
            begin
                pcWrite = instrValid;       // Only on the accept cycle
                irWrite = instrValid;
                aluSrcA = srcAPc;
                aluSrcB = srcBFour;
            end
            stDecode:
            begin
                aluSrcA      = srcAPc;      // Branch target into ALUOut
                aluSrcB      = srcBBranchOff;
                illegalInstr = (dec.instrClass == clsIllegal);
            end
            stMemAddr:
            begin
                aluSrcB = srcBImm;
            end
            stMemLoad:
            begin
                memRead = 1'b1;
            end
            stLoadWb:
            begin
                regWrite = 1'b1;
                memToReg = wbMem;
            end
            stMemStore:
            begin
                memWrite = 1'b1;
            end
            stExecute:
            begin
                aluSrcA = dec.aluSrcA;
                aluSrcB = dec.aluSrcB;
                aluOp   = dec.aluOp;
            end
            stAluWb:
            begin
                regWrite = 1'b1;
                regDst   = dec.regDst;
            end
            stBranch:
            begin
                pcWriteCond = 1'b1;
                pcSrc       = pcBranch;
                aluOp       = dec.aluOp;   // aluSub for beq
            end
            stJump:
            begin
                pcWrite  = 1'b1;
                pcSrc    = dec.isRtype ? pcReg : pcJump;
                regWrite = dec.link;
                regDst   = dstRa;
                memToReg = wbPcPlus4;
            end
            default:
            begin
                pcSrc = pcPlus4;
            end
        endcase
    end

endmodule

//--- hw/ctrlSequencer.sv
module ctrlSequencer (
    input  logic               clk,
    input  logic               arstN,
    input  logic               instrValid,
    output logic               instrReady,
    output ctrlPkg::ctrlStateT state,
    decodeIf.sequencer         dec
);
    import ctrlPkg::*;

    ctrlStateT stateNext;

    assign instrReady = (state == stFetch);
    assign dec.accept = instrReady & instrValid;

    always_comb
    begin
        stateNext = state;
        case (state)
            stFetch:
            begin
                if (dec.accept)
                begin
                    stateNext = stDecode;
                end
            end
            stDecode:
            begin
                case (dec.instrClass)
                    clsAlu:             stateNext = stExecute;
                    clsLoad, clsStore:  stateNext = stMemAddr;
                    clsBranch:          stateNext = stBranch;
                    clsJump:            stateNext = stJump;
                    default:            stateNext = stFetch;  // Illegal code
                endcase
            end
            stMemAddr:
            begin
                if (dec.instrClass == clsLoad)
                begin
                    stateNext = stMemLoad;
                end
                else
                begin
                    stateNext = stMemStore;
                end
            end
            stMemLoad:  stateNext = stLoadWb;
            stExecute:  stateNext = stAluWb;
            stLoadWb,
            stMemStore,
            stAluWb,
            stBranch,
            stJump:     stateNext = stFetch;
            default:    stateNext = stFetch;
        endcase
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            state <= stFetch;
        end
        else
        begin
            state <= stateNext;
        end
    end

endmodule

//--- hw/instrDecoder.sv
module instrDecoder (
    input  logic        clk,
    input  logic        arstN,
    input  logic [5:0]  op,
    input  logic [5:0]  funct,
    decodeIf.decoder    dec
);
    import ctrlPkg::*;

    instrClassT classNext;
    aluOpT      aluOpNext;
    aluSrcAT    srcANext;
    aluSrcBT    srcBNext;
    regDstT     dstNext;
    logic       linkNext;

    always_comb
    begin
        classNext = clsIllegal;
        aluOpNext = aluAdd;
        srcANext  = srcARegA;
        srcBNext  = srcBImm;          // I-type unless overridden
        dstNext   = dstRt;
        linkNext  = 1'b0;
        case (op)
            opRtype:
            begin
                classNext = clsAlu;
                srcBNext  = srcBRegB;
                dstNext   = dstRd;
                case (funct)
                    fnAdd, fnAddu: aluOpNext = aluAdd;
                    fnSub, fnSubu: aluOpNext = aluSub;
                    fnAnd:         aluOpNext = aluAnd;
                    fnOr:          aluOpNext = aluOr;
                    fnXor:         aluOpNext = aluXor;
                    fnNor:         aluOpNext = aluNor;
                    fnSllv:        aluOpNext = aluSll;
                    fnSrlv:        aluOpNext = aluSrl;
                    fnSll:
                    begin
                        aluOpNext = aluSll;
                        srcANext  = srcAShamt;
                    end
                    fnSrl:
                    begin
                        aluOpNext = aluSrl;
                        srcANext  = srcAShamt;
                    end
                    fnJr:          classNext = clsJump;
                    fnJalr:
                    begin
                        classNext = clsJump;
                        linkNext  = 1'b1;
                    end
                    default:       classNext = clsIllegal;
                endcase
            end
            opAddi, opAddiu: {classNext, aluOpNext} = {clsAlu, aluAdd};
            opSlti:          {classNext, aluOpNext} = {clsAlu, aluSlt};
            opSltiu:         {classNext, aluOpNext} = {clsAlu, aluSltu};
            opAndi:          {classNext, aluOpNext} = {clsAlu, aluAnd};
            opOri:           {classNext, aluOpNext} = {clsAlu, aluOr};
            opXori:          {classNext, aluOpNext} = {clsAlu, aluXor};
            opLui:           {classNext, aluOpNext} = {clsAlu, aluLui};
            opLw:            classNext = clsLoad;
            opSw:            classNext = clsStore;
            opBeq:           {classNext, aluOpNext, srcBNext} = {clsBranch, aluSub, srcBRegB};
            opBne:           {classNext, aluOpNext, srcBNext} = {clsBranch, aluBne, srcBRegB};
            opBlez:          {classNext, aluOpNext, srcBNext} = {clsBranch, aluBlez, srcBRegB};
            opBgtz:          {classNext, aluOpNext, srcBNext} = {clsBranch, aluBgtz, srcBRegB};
            opJ:             classNext = clsJump;
            opJal:
            begin
                classNext = clsJump;
                linkNext  = 1'b1;
            end
            default:         classNext = clsIllegal;
        endcase
    end

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
        begin
            dec.instrClass <= clsIllegal;
            dec.aluOp      <= aluAdd;
            dec.aluSrcA    <= srcARegA;
            dec.aluSrcB    <= srcBRegB;
            dec.regDst     <= dstRt;
            dec.isRtype    <= 1'b0;
            dec.link       <= 1'b0;
        end
        else if (dec.accept)           // Hold fields until next fetch
        begin
            dec.instrClass <= classNext;
            dec.aluOp      <= aluOpNext;
            dec.aluSrcA    <= srcANext;
            dec.aluSrcB    <= srcBNext;
            dec.regDst     <= dstNext;
            dec.isRtype    <= (op == opRtype);
            dec.link       <= linkNext;
        end
    end

endmodule

//--- hw/decodeIf.sv
interface decodeIf;
    import ctrlPkg::*;

    logic       accept;     // Handshake fire
    instrClassT instrClass;
    aluOpT      aluOp;
    aluSrcAT    aluSrcA;
    aluSrcBT    aluSrcB;
    regDstT     regDst;
    logic       isRtype;
    logic       link;       // jal and jalr write ra

    modport decoder (
        input  accept,
        output instrClass, aluOp, aluSrcA, aluSrcB, regDst, isRtype, link
    );

    modport sequencer (
        output accept,
        input  instrClass, link
    );

    modport outputs (
        input instrClass, aluOp, aluSrcA, aluSrcB, regDst, isRtype, link
    );

endinterface

//--- hw/ctrlPkg.sv
package ctrlPkg;

    // Primary opcodes
    localparam logic [5:0] opRtype = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opJal   = 6'h03;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opBne   = 6'h05;
    localparam logic [5:0] opBlez  = 6'h06;
    localparam logic [5:0] opBgtz  = 6'h07;
    localparam logic [5:0] opAddi  = 6'h08;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opSlti  = 6'h0a;
    localparam logic [5:0] opSltiu = 6'h0b;
    localparam logic [5:0] opAndi  = 6'h0c;
    localparam logic [5:0] opOri   = 6'h0d;
    localparam logic [5:0] opXori  = 6'h0e;
    localparam logic [5:0] opLui   = 6'h0f;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;

    // Function field of R-type
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnSrl  = 6'h02;
    localparam logic [5:0] fnSllv = 6'h04;
    localparam logic [5:0] fnSrlv = 6'h06;
    localparam logic [5:0] fnJr   = 6'h08;
    localparam logic [5:0] fnJalr = 6'h09;
    localparam logic [5:0] fnAdd  = 6'h20;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSub  = 6'h22;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnXor  = 6'h26;
    localparam logic [5:0] fnNor  = 6'h27;

    typedef enum logic [3:0] {
        stFetch,
        stDecode,
        stMemAddr,
        stMemLoad,
        stLoadWb,
        stMemStore,
        stExecute,
        stAluWb,
        stBranch,
        stJump
    } ctrlStateT;

    typedef enum logic [2:0] {
        clsAlu,
        clsLoad,
        clsStore,
        clsBranch,
        clsJump,
        clsIllegal
    } instrClassT;

    typedef enum logic [4:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluXor,
        aluNor,
        aluSll,
        aluSrl,
        aluSlt,
        aluSltu,
        aluLui,
        aluBne,
        aluBgtz,
        aluBlez
    } aluOpT;

    typedef enum logic [1:0] {srcARegA, srcAPc, srcAShamt} aluSrcAT;
    typedef enum logic [1:0] {srcBRegB, srcBFour, srcBImm, srcBBranchOff} aluSrcBT;
    typedef enum logic [1:0] {dstRt, dstRd, dstRa} regDstT;
    typedef enum logic [1:0] {wbMem, wbAlu, wbPcPlus4} memToRegT;
    typedef enum logic [1:0] {pcPlus4, pcBranch, pcJump, pcReg} pcSrcT;

endpackage
